/* hw/soqpsk_macros.svh */
// sizes and constants for the four-state SOQPSK trellis detector
// include wherever a width, the energy term or the fill depth is needed

`ifndef SOQPSK_MACROS_SVH
`define SOQPSK_MACROS_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------
`define SOQPSK_SAMPLE_W 8    // signed soft sample from the matched filter
`define SOQPSK_METRIC_W 12   // branch and path metrics, modulo arithmetic

// ---------------------------------------------------------------------------
// trellis constants
// ---------------------------------------------------------------------------
// energy term taken off a branch with a nonzero ternary level,
// about the nominal amplitude of a noise-free sample
`define SOQPSK_ENERGY 64

// symbols accepted before the first decision leaves the pipe
`define SOQPSK_FILL 3        // BM, ACS and trace back stages

`endif

/* hw/soqpskPkg.sv */
// types shared by the SOQPSK detector stages
// referenced by scoped name from the stage modules and the top level

`include "soqpsk_macros.svh"

package soqpskPkg;

   // ------------------------------------------------------------------------
   // scalar types
   // ------------------------------------------------------------------------
   // path and branch metric, compared modulo 2**SOQPSK_METRIC_W
   typedef logic signed [`SOQPSK_METRIC_W-1:0] metric_t;

   // trellis state, two bits
   typedef logic [1:0] state_t;

   // ------------------------------------------------------------------------
   // stage payloads
   // ------------------------------------------------------------------------
   // one soft symbol as it arrives on the input handshake
   typedef struct packed {
      logic signed [`SOQPSK_SAMPLE_W-1:0] sample;  // +/- amplitude plus noise
   } softSym_t;

   // ternary branch metrics of one sample
   typedef struct packed {
      metric_t bmZero;   // level 0, always zero
      metric_t bmPlus;   // level +1
      metric_t bmMinus;  // level -1
   } branchMetrics_t;

   // ACS result for one symbol, handed to trace back
   typedef struct packed {
      logic [3:0] sel;    // survivor bit per destination state
      state_t     index;  // best state after this symbol
      logic       even;   // parity of this symbol, 1 = even
   } acsOut_t;

endpackage

/* hw/branchMetricSoqpsk.sv */
// first detector stage, registers the three ternary branch metrics of a sample
// metrics move only when a symbol is accepted

`timescale 1ns/10ps
`include "soqpsk_macros.svh"

module branchMetricSoqpsk (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      advance,  // one pulse per accepted symbol
   input  soqpskPkg::softSym_t       inSym,
   output soqpskPkg::branchMetrics_t metrics
);

   localparam int MW = `SOQPSK_METRIC_W;
   localparam int SW = `SOQPSK_SAMPLE_W;
   localparam soqpskPkg::metric_t ENERGY = `SOQPSK_ENERGY;

   soqpskPkg::metric_t xWide;   // sample at metric width
   soqpskPkg::metric_t twoX;    // 2x, cannot overflow at this width
   soqpskPkg::metric_t plusBm;
   soqpskPkg::metric_t minusBm;

   // ------------------------------------------------------------------------
   // metric arithmetic
   // ------------------------------------------------------------------------
   // sign extend first so the doubling stays exact
   assign xWide = {{(MW-SW){inSym.sample[SW-1]}}, inSym.sample};
   assign twoX  = xWide + xWide;

   // correlation with +1 / -1, less the energy of a nonzero level
   assign plusBm  = twoX - ENERGY;    // 2x - E
   assign minusBm = -twoX - ENERGY;   // -2x - E

   // ------------------------------------------------------------------------
   // stage register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         metrics <= '0;               // zero metrics, first ACS step is a no-op
      end else if (advance) begin
         metrics.bmZero  <= '0;       // level 0 adds nothing
         metrics.bmPlus  <= plusBm;
         metrics.bmMinus <= minusBm;
      end
   end

   // worst case is x = -128, giving -320 and +192, both well inside MW bits
   // so the doubled value and the energy term never wrap here

   // the zero metric is kept in the struct so the ACS sees one uniform
   // add per branch, whatever the level

endmodule

/* hw/acsSoqpsk.sv */
// four-state add-compare-select for the SOQPSK trellis
// keeps the path metrics and symbol parity, reports survivors and best state

`timescale 1ns/10ps
`include "soqpsk_macros.svh"

module acsSoqpsk (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      advance,
   input  soqpskPkg::branchMetrics_t metrics,
   output soqpskPkg::acsOut_t        acsOut
);

   localparam int MW = `SOQPSK_METRIC_W;

   soqpskPkg::metric_t pm [4];       // path metric per state
   soqpskPkg::metric_t pmNext [4];   // selected and normalized
   soqpskPkg::metric_t normOffset;   // state-0 metric once its top bit is up
   logic [3:0]         selNext;      // b of each survivor
   soqpskPkg::state_t  bestNext;
   soqpskPkg::state_t  mask;         // 1 on odd symbols, 2 on even
   logic               evenNext;     // parity of the symbol now in metrics

   // modulo compare, valid while the metric spread stays under half range
   function automatic logic greater(input soqpskPkg::metric_t a,
                                    input soqpskPkg::metric_t b);
      soqpskPkg::metric_t diff;
      diff = a - b;
      return !diff[MW-1] && (diff != '0);
   endfunction

   // ------------------------------------------------------------------------
   // parity and mask
   // ------------------------------------------------------------------------
   // the word left by reset stands for symbol -1, so parity flips on every
   // step and the first real symbol comes out odd. that dummy step sees
   // zero metrics and leaves all path metrics at zero
   assign evenNext = ~acsOut.even;
   assign mask     = evenNext ? 2'd2 : 2'd1;

   // normalize when state 0 has grown into the top bit
   assign normOffset = pm[0][MW-1] ? pm[0] : '0;

   // ------------------------------------------------------------------------
   // add-compare-select
   // ------------------------------------------------------------------------
   always_comb begin : acsStep
      soqpskPkg::state_t  dst;
      soqpskPkg::state_t  src;
      soqpskPkg::metric_t bm;
      soqpskPkg::metric_t stay;
      soqpskPkg::metric_t move;
      for (int s = 0; s < 4; s++) begin
         dst = soqpskPkg::state_t'(s);
         src = dst ^ mask;                       // b = 1 predecessor
         // level +1 when the masked destination bit is set
         bm = ((dst & mask) != '0) ? metrics.bmPlus : metrics.bmMinus;
         stay = pm[s] + metrics.bmZero;          // b = 0 keeps the state
         move = pm[src] + bm;
         selNext[s] = greater(move, stay);       // tie keeps b = 0
         pmNext[s] = (selNext[s] ? move : stay) - normOffset;
      end
   end

   // ------------------------------------------------------------------------
   // best state, lowest index wins a tie
   // ------------------------------------------------------------------------
   always_comb begin : bestSearch
      soqpskPkg::metric_t bestMetric;
      bestNext   = '0;
      bestMetric = pmNext[0];
      for (int s = 1; s < 4; s++) begin
         if (greater(pmNext[s], bestMetric)) begin
            bestNext   = soqpskPkg::state_t'(s);
            bestMetric = pmNext[s];
         end
      end
   end

   // ------------------------------------------------------------------------
   // stage registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         pm     <= '{default: '0};
         acsOut <= '0;                 // even = 0, parity starts odd
      end else if (advance) begin
         pm           <= pmNext;
         acsOut.sel   <= selNext;
         acsOut.index <= bestNext;
         acsOut.even  <= evenNext;
      end
   end

   // path metrics never shrink before normalization, the b = 0 branch adds 0.
   // every state is reachable from any other in two steps, which bounds
   // the spread to roughly 1k and keeps the modulo compare honest

   // once the top bit is seen the next step must bring state 0 back down
   normCheck: assert property (
      @(posedge clk) disable iff (reset)
      (advance && pm[0][MW-1]) |=> !pm[0][MW-1]
   ) else $error("state-0 metric kept its top bit over two advances");

endmodule

/* hw/traceBackSoqpsk.sv */
// one-step trace back from the best state of the latest symbol
// gives the decision for the symbol before it

`timescale 1ns/10ps

module traceBackSoqpsk (
   input  logic               clk,
   input  logic               reset,
   input  logic               symEn,     // one enable per accepted symbol
   input  soqpskPkg::acsOut_t acsOut,
   output logic               decision
);

   logic [3:0]        selDly;     // survivors of the previous symbol
   soqpskPkg::state_t mask;
   soqpskPkg::state_t prevState;  // predecessor of the best state

   // odd symbols pair 0/1 and 2/3, even symbols pair 0/2 and 1/3
   assign mask = acsOut.even ? 2'd2 : 2'd1;

   // step back along the survivor of the best state
   assign prevState = acsOut.sel[acsOut.index] ? (acsOut.index ^ mask)
                                               : acsOut.index;

   always_ff @(posedge clk) begin
      if (reset) begin
         selDly <= '0;
      end else if (symEn) begin
         selDly <= acsOut.sel;    // one symbol delay
      end
   end

   // bit of the previous symbol that led into prevState
   assign decision = selDly[prevState];

   idxKnown: assert property (
      @(posedge clk) disable iff (reset)
      symEn |-> !$isunknown(acsOut.index)
   ) else $error("best state index unknown on a symbol enable");

endmodule

/* hw/soqpskTrellisDetector.sv */
// SOQPSK hard-decision trellis detector, valid/ready in and out
// one soft sample in per symbol, one bit out per symbol after a fill of three

`timescale 1ns/10ps
`include "soqpsk_macros.svh"

module soqpskTrellisDetector (
   input  logic                clk,
   input  logic                reset,
   input  logic                inValid,
   input  soqpskPkg::softSym_t inSym,
   output logic                inReady,
   output logic                outValid,
   output logic                outBit,
   input  logic                outReady
);

   localparam int FILL   = `SOQPSK_FILL;
   localparam int FILL_W = $clog2(FILL + 1);

   logic                      advance;    // input transfer, moves every stage
   logic [FILL_W-1:0]         fillCnt;    // saturates at FILL
   logic                      fillDone;
   soqpskPkg::branchMetrics_t metrics;
   soqpskPkg::acsOut_t        acsOut;
   logic                      decision;

   // ------------------------------------------------------------------------
   // handshake and pipeline advance
   // ------------------------------------------------------------------------
   assign inReady  = !outValid || outReady;   // room once the output drains
   assign advance  = inValid && inReady;
   assign fillDone = (fillCnt == FILL_W'(FILL));

   always_ff @(posedge clk) begin
      if (reset) begin
         fillCnt <= '0;
      end else if (advance && !fillDone) begin
         fillCnt <= fillCnt + 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // stages
   // ------------------------------------------------------------------------
   branchMetricSoqpsk i_branchMetric (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .inSym   (inSym),
      .metrics (metrics)
   );

   acsSoqpsk i_acs (
      .clk     (clk),
      .reset   (reset),
      .advance (advance),
      .metrics (metrics),
      .acsOut  (acsOut)
   );

   traceBackSoqpsk i_traceBack (
      .clk      (clk),
      .reset    (reset),
      .symEn    (advance),
      .acsOut   (acsOut),
      .decision (decision)
   );

   // ------------------------------------------------------------------------
   // output register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         outValid <= 1'b0;
      end else if (advance) begin
         outValid <= fillDone;        // decision for symbol k on advance k+3
      end else if (outReady) begin
         outValid <= 1'b0;            // taken, nothing new behind it
      end
   end

   always_ff @(posedge clk) begin
      if (advance) outBit <= decision;
   end

   stallHold: assert property (
      @(posedge clk) disable iff (reset)
      (outValid && !outReady) |=> $stable(outBit)
   ) else $error("outBit changed while the output was stalled");

endmodule

/* verification/clockGen.sv */
// clock and reset source for the detector testbench
// 40 ns clock, reset held high over the first 8 rising edges

`timescale 1ns/10ps

module clockGen #(
   parameter int HALF_PERIOD  = 20,   // ns
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 reset = 1'b0;                 // off the edge, same as the data inputs
   end

endmodule

/* verification/tbSoqpskDetector.sv */
// testbench for the SOQPSK trellis detector
// plays the symbol trace with random input gaps and output stalls and checks each decision

`timescale 1ns/10ps
`include "soqpsk_macros.svh"

module tbSoqpskDetector;

   localparam logic [31:0] SEED = 32'h80b3_0a14;
   localparam int    DRIVE_DLY  = 2;                   // ns after the rising edge
   localparam int    FIRST_OUT  = `SOQPSK_FILL + 1;    // acceptances before outValid may rise
   localparam int    SW         = `SOQPSK_SAMPLE_W;
   localparam string TRACE      = "verification/soqpsk_trace.txt";

   logic                clk;
   logic                reset;
   logic                inValid;
   soqpskPkg::softSym_t inSym;
   logic                inReady;
   logic                outValid;
   logic                outBit;
   logic                outReady;

   logic [SW-1:0] samples[$];    // one soft sample per symbol
   logic          expected[$];   // decisions still owed in order
   int            errors;
   int            checks;

   clockGen i_clockGen (.clk(clk), .reset(reset));

   soqpskTrellisDetector i_soqpskTrellisDetector (
      .clk      (clk),
      .reset    (reset),
      .inValid  (inValid),
      .inSym    (inSym),
      .inReady  (inReady),
      .outValid (outValid),
      .outBit   (outBit),
      .outReady (outReady)
   );

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   // columns are sample, flag, bit; lines opening with # are notes
   task automatic loadTrace();
      int    fd;
      int    n;
      int    sample;
      int    flag;
      int    bitVal;
      string line;
      fd = $fopen(TRACE, "r");
      if (fd == 0) begin
         $display("could not open the trace file %s", TRACE);
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n == 0 || line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%d %d %d", sample, flag, bitVal);
         if (n != 3) begin
            $display("trace line could not be read: %s", line);
            errors++;
         end else begin
            samples.push_back(sample[SW-1:0]);
            if (flag != 0) expected.push_back(bitVal[0]);   // pad lines owe nothing
         end
      end
      $fclose(fd);
   endtask

   task automatic compareBit(input string name, input logic got, input logic want);
      checks++;
      assert (got === want) else begin
         $display("CHECK FAILED t=%0t %s expected %0b got %0b", $time, name, want, got);
         errors++;
      end
   endtask

   // a quarter of the cycles idle on the input and a quarter stalled on the output
   task automatic driveInputs(input int idx);
      logic gap;
      logic stall;
      gap          = ($urandom % 4) == 0;
      stall        = ($urandom % 4) == 0;
      inValid      = (idx < samples.size()) && !gap;
      inSym.sample = (idx < samples.size()) ? samples[idx] : '0;
      outReady     = !stall;
   endtask

   // ------------------------------------------------------------------------
   // run
   // ------------------------------------------------------------------------
   initial begin : run
      int   idx;          // next trace line to offer
      int   accepted;     // input transfers so far
      int   decisions;    // output transfers so far
      int   nExpected;
      int   cycle;
      int   cycleLimit;
      int   drain;        // quiet cycles after the last decision
      logic stalled;
      logic heldBit;
      errors    = 0;
      checks    = 0;
      inValid   = 1'b0;
      inSym     = '0;
      outReady  = 1'b0;
      idx       = 0;
      accepted  = 0;
      decisions = 0;
      cycle     = 0;
      drain     = 0;
      stalled   = 1'b0;
      heldBit   = 1'b0;
      void'($urandom(SEED));
      loadTrace();
      nExpected  = expected.size();
      cycleLimit = 4 * samples.size() + 50;   // four cycles a symbol plus fill and drain

      @(negedge reset);
      driveInputs(idx);
      while (drain < 4 && cycle < cycleLimit) begin
         @(negedge clk);                          // read handshakes once all has settled
         cycle++;
         if (accepted < FIRST_OUT) compareBit("outValid", outValid, 1'b0);
         if (stalled) compareBit("outBit", outBit, heldBit);   // must hold in a stall
         // input blocked only by a waiting decision that is not taken
         if (outValid && !outReady) compareBit("inReady", inReady, 1'b0);
         else compareBit("inReady", inReady, 1'b1);
         if (outValid && outReady) begin
            decisions++;
            checks++;
            assert (expected.size() > 0) else begin
               $display("t=%0t the DUT sent a decision after all were received", $time);
               errors++;
            end
            if (expected.size() > 0) compareBit("outBit", outBit, expected.pop_front());
         end
         stalled = outValid && !outReady;
         heldBit = outBit;
         if (inValid && inReady) begin
            idx++;
            accepted++;
         end
         @(posedge clk);
         #DRIVE_DLY;
         driveInputs(idx);
         if (idx == samples.size() && decisions >= nExpected) drain++;
      end

      if (drain < 4) begin
         $display("timeout after %0d cycles with %0d of %0d symbols accepted",
                  cycle, accepted, samples.size());
         errors++;
      end
      checks++;
      assert (decisions == nExpected) else begin
         $display("CHECK FAILED t=%0t decision count expected %0d got %0d",
                  $time, nExpected, decisions);
         errors++;
      end
      $display("checks %0d, errors %0d, decisions %0d of %0d",
               checks, errors, decisions, nExpected);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* verification/soqpsk_trace.txt */
# sample (signed decimal), flag 1 when a decision is owed, expected bit
# noise-free +/-64, noisy, full scale +/-127, then three pad symbols
64 1 1
64 1 1
0 1 0
-64 1 1
-64 1 1
64 1 1
64 1 1
0 1 0
0 1 0
-64 1 1
-45 1 1
13 1 0
42 1 1
81 1 1
-24 1 0
-79 1 1
28 1 0
37 1 1
-127 1 1
-127 1 1
127 1 1
127 1 1
-127 1 1
-127 1 1
127 1 1
127 1 1
-127 1 1
-127 1 1
0 0 0
0 0 0
0 0 0

/* list.f */
+incdir+hw
hw/soqpskPkg.sv
hw/branchMetricSoqpsk.sv
hw/acsSoqpsk.sv
hw/traceBackSoqpsk.sv
hw/soqpskTrellisDetector.sv
verification/clockGen.sv
verification/tbSoqpskDetector.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the SOQPSK detector testbench with Verilator.
# Exits 0 only when the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tbSoqpskDetector
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module "$TOP" -f list.f -o "$TOP" > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1
